//--- alu_op_pkg.sv
`default_nettype none

package alu_op_pkg;

    // Operands are rj and rk, MERGE also reads the old rd
    typedef enum logic [3:0] {
        ALU_ADD   = 4'h0,  // rj + rk
        ALU_SUB   = 4'h1,  // rj - rk
        ALU_AND   = 4'h2,
        ALU_OR    = 4'h3,
        ALU_XOR   = 4'h4,
        ALU_SLL   = 4'h5,  // Shift amount is rk[4:0]
        ALU_SRL   = 4'h6,  // Logical, zero fill
        ALU_SLT   = 4'h7,  // Signed compare, result is 0 or 1
        ALU_MERGE = 4'h8   // rj where rk is set, old rd elsewhere
    } alu_op_e;

endpackage

`default_nettype wire

//--- exe_cfg_pkg.sv
`default_nettype none

package exe_cfg_pkg;

    localparam int DATA_W    = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_IDX_W = $clog2(REG_COUNT);
    localparam int SHAMT_W   = 5;  // Shifts use the low bits of rk only
    localparam int MAX_LANES = 2;

    // Each lane reads rj, rk and its old rd, in this slot order
    localparam int SRC_PER_LANE = 3;
    localparam int OP_J = 0;
    localparam int OP_K = 1;
    localparam int OP_D = 2;

    typedef logic [DATA_W-1:0]             data_t;
    typedef logic [REG_IDX_W-1:0]          reg_idx_t;
    typedef logic [SHAMT_W-1:0]            shamt_t;
    typedef logic [$clog2(MAX_LANES)-1:0]  lane_idx_t;

endpackage

`default_nettype wire

//--- exe_lane.sv
`timescale 1ns/1ns
`default_nettype none

module exe_lane import exe_cfg_pkg::*, alu_op_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    exe0_if.lane ex0,
    stage_if.src s1,
    stage_if.src s2,
    stage_if.src s3
);

    data_t  alu_res;
    shamt_t shamt;

    assign shamt = ex0.opk[SHAMT_W-1:0];

    always_comb begin
        case (ex0.op)
            ALU_ADD:   alu_res = ex0.opj + ex0.opk;
            ALU_SUB:   alu_res = ex0.opj - ex0.opk;
            ALU_AND:   alu_res = ex0.opj & ex0.opk;
            ALU_OR:    alu_res = ex0.opj | ex0.opk;
            ALU_XOR:   alu_res = ex0.opj ^ ex0.opk;
            ALU_SLL:   alu_res = ex0.opj << shamt;
            ALU_SRL:   alu_res = ex0.opj >> shamt;
            ALU_SLT:   alu_res = data_t'($signed(ex0.opj) < $signed(ex0.opk));
            ALU_MERGE: alu_res = (ex0.opj & ex0.opk) | (ex0.opd & ~ex0.opk);
            default:   alu_res = '0;
        endcase
    end

    // Control flags of the three stage registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1.valid <= 1'b0;
            s1.wen   <= 1'b0;
            s2.valid <= 1'b0;
            s2.wen   <= 1'b0;
            s3.valid <= 1'b0;
            s3.wen   <= 1'b0;
        end else begin
            s1.valid <= ex0.valid;
            s1.wen   <= ex0.valid && (ex0.rd != '0);  // r0 results are dropped here
            s2.valid <= s1.valid;
            s2.wen   <= s1.wen;
            s3.valid <= s2.valid;
            s3.wen   <= s2.wen;
        end
    end

    always_ff @(posedge clk) begin
        s1.rd     <= ex0.rd;
        s1.result <= alu_res;
        s2.rd     <= s1.rd;
        s2.result <= s1.result;
        s3.rd     <= s2.rd;
        s3.result <= s2.result;
    end

    // Opcodes come straight from the issue ports of the top level
    a_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
        ex0.valid |-> !$isunknown(ex0.op) && ex0.op inside {ALU_ADD, ALU_SUB, ALU_AND,
            ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SLT, ALU_MERGE});

endmodule

`default_nettype wire

//--- exe_top.sv
`timescale 1ns/1ns
`default_nettype none

module exe_top import exe_cfg_pkg::*, alu_op_pkg::*; #(
    parameter int LANES = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic     [LANES-1:0] issue_valid,
    input  alu_op_e  [LANES-1:0] issue_op,
    input  reg_idx_t [LANES-1:0] issue_rj,
    input  reg_idx_t [LANES-1:0] issue_rk,
    input  reg_idx_t [LANES-1:0] issue_rd,
    output logic     [LANES-1:0] wb_valid,
    output reg_idx_t [LANES-1:0] wb_rd,
    output data_t    [LANES-1:0] wb_data
);

    reg_idx_t [SRC_PER_LANE*LANES-1:0] rf_raddr;
    data_t    [SRC_PER_LANE*LANES-1:0] rf_rdata;

    stage_if s1 [LANES] ();  // exe0_exe1
    stage_if s2 [LANES] ();  // exe1_exe2
    stage_if s3 [LANES] ();  // exe2_wb
    exe0_if  ex0 [LANES] ();

    operand_forward #(
        .LANES (LANES)
    ) i_fwd (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rj    (issue_rj),
        .issue_rk    (issue_rk),
        .issue_rd    (issue_rd),
        .rf_raddr    (rf_raddr),
        .rf_rdata    (rf_rdata),
        .s1          (s1),
        .s2          (s2),
        .s3          (s3),
        .ex0         (ex0)
    );

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        exe_lane i_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .ex0   (ex0[l]),
            .s1    (s1[l]),
            .s2    (s2[l]),
            .s3    (s3[l])
        );
    end

    // Write ports drain exe2_wb and double as the writeback outputs
    reg_file #(
        .LANES (LANES)
    ) i_rf (
        .clk      (clk),
        .raddr    (rf_raddr),
        .rdata    (rf_rdata),
        .wb       (s3),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
exe_cfg_pkg.sv
alu_op_pkg.sv
stage_if.sv
reg_file.sv
operand_forward.sv
exe_lane.sv
exe_top.sv
tb_exe_top.sv

//--- operand_forward.sv
`timescale 1ns/1ns
`default_nettype none

module operand_forward import exe_cfg_pkg::*, alu_op_pkg::*; #(
    parameter int LANES = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic     [LANES-1:0]              issue_valid,
    input  alu_op_e  [LANES-1:0]              issue_op,
    input  reg_idx_t [LANES-1:0]              issue_rj,
    input  reg_idx_t [LANES-1:0]              issue_rk,
    input  reg_idx_t [LANES-1:0]              issue_rd,
    output reg_idx_t [SRC_PER_LANE*LANES-1:0] rf_raddr,
    input  data_t    [SRC_PER_LANE*LANES-1:0] rf_rdata,
    stage_if.fwd                              s1 [LANES],
    stage_if.fwd                              s2 [LANES],
    stage_if.fwd                              s3 [LANES],
    exe0_if.drv                               ex0 [LANES]
);

    localparam int NSRC = SRC_PER_LANE * LANES;
    localparam int NSTG = 3;

    logic     [LANES-1:0] ex0_valid;
    alu_op_e  [LANES-1:0] ex0_op;
    reg_idx_t [NSRC-1:0]  ex0_src;
    data_t    [NSRC-1:0]  ex0_rf;
    data_t    [NSRC-1:0]  fwd_data;

    // Index 0 is s1 (youngest), 2 is s3
    logic     stg_wen [NSTG][LANES];
    reg_idx_t stg_rd  [NSTG][LANES];
    data_t    stg_res [NSTG][LANES];

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            rf_raddr[l*SRC_PER_LANE + OP_J] = issue_rj[l];
            rf_raddr[l*SRC_PER_LANE + OP_K] = issue_rk[l];
            rf_raddr[l*SRC_PER_LANE + OP_D] = issue_rd[l];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex0_valid <= '0;
        end else begin
            ex0_valid <= issue_valid;
        end
    end

    // Register file data is sampled with the instruction, write-through included
    always_ff @(posedge clk) begin
        ex0_op  <= issue_op;
        ex0_src <= rf_raddr;
        ex0_rf  <= rf_rdata;
    end

    for (genvar l = 0; l < LANES; l++) begin : g_stage
        assign stg_wen[0][l] = s1[l].wen;
        assign stg_rd[0][l]  = s1[l].rd;
        assign stg_res[0][l] = s1[l].result;
        assign stg_wen[1][l] = s2[l].wen;
        assign stg_rd[1][l]  = s2[l].rd;
        assign stg_res[1][l] = s2[l].result;
        assign stg_wen[2][l] = s3[l].wen;
        assign stg_rd[2][l]  = s3[l].rd;
        assign stg_res[2][l] = s3[l].result;
    end

    // Walk from oldest to youngest so the last match is the youngest producer.
    // wen is never set for r0, so source r0 keeps the zero from the register file
    always_comb begin
        for (int p = 0; p < NSRC; p++) begin
            fwd_data[p] = ex0_rf[p];
            for (int s = NSTG - 1; s >= 0; s--) begin
                for (int l = 0; l < LANES; l++) begin
                    if (stg_wen[s][l] && stg_rd[s][l] == ex0_src[p]) begin
                        fwd_data[p] = stg_res[s][l];
                    end
                end
            end
        end
    end

    for (genvar l = 0; l < LANES; l++) begin : g_ex0
        localparam int BASE = l * SRC_PER_LANE;

        assign ex0[l].valid = ex0_valid[l];
        assign ex0[l].op    = ex0_op[l];
        assign ex0[l].rd    = ex0_src[BASE + OP_D];
        assign ex0[l].opj   = fwd_data[BASE + OP_J];
        assign ex0[l].opk   = fwd_data[BASE + OP_K];
        assign ex0[l].opd   = fwd_data[BASE + OP_D];

        // Old rd only counts as an operand for MERGE
        a_operand_known: assert property (@(posedge clk) disable iff (!rst_n)
            ex0_valid[l] |-> !$isunknown({fwd_data[BASE + OP_J], fwd_data[BASE + OP_K]})
                && (ex0_op[l] != ALU_MERGE || !$isunknown(fwd_data[BASE + OP_D])));
    end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file import exe_cfg_pkg::*; #(
    parameter int LANES = 2
) (
    input  logic                              clk,
    input  reg_idx_t [SRC_PER_LANE*LANES-1:0] raddr,
    output data_t    [SRC_PER_LANE*LANES-1:0] rdata,
    stage_if.wb                               wb [LANES],
    output logic     [LANES-1:0]              wb_valid,
    output reg_idx_t [LANES-1:0]              wb_rd,
    output data_t    [LANES-1:0]              wb_data
);

    localparam int NPORTS = SRC_PER_LANE * LANES;

    data_t     mem [REG_COUNT];

    logic      lane_wen   [LANES];
    logic      lane_valid [LANES];
    reg_idx_t  lane_rd    [LANES];
    data_t     lane_data  [LANES];

    logic      [NPORTS-1:0] hit;
    lane_idx_t hit_lane [NPORTS];

    for (genvar l = 0; l < LANES; l++) begin : g_wb
        assign lane_wen[l]   = wb[l].wen;
        assign lane_valid[l] = wb[l].valid;
        assign lane_rd[l]    = wb[l].rd;
        assign lane_data[l]  = wb[l].result;

        // A write to r0 would break the zero returned by the read mux only by accident
        a_no_r0_write: assert property (@(posedge clk) lane_wen[l] |-> lane_rd[l] != '0);

        a_wen_rd_known: assert property (@(posedge clk)
            lane_wen[l] |-> lane_valid[l] && !$isunknown(lane_rd[l]));
    end

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            wb_valid[l] = lane_wen[l];  // r0 targets never show up as writebacks
            wb_rd[l]    = lane_rd[l];
            wb_data[l]  = lane_data[l];
        end
    end

    // Higher lane is younger and is written last, so it wins on equal rd
    always_ff @(posedge clk) begin
        for (int l = 0; l < LANES; l++) begin
            if (lane_wen[l]) begin
                mem[lane_rd[l]] <= lane_data[l];
            end
        end
    end

    always_comb begin
        for (int p = 0; p < NPORTS; p++) begin
            hit[p]      = 1'b0;
            hit_lane[p] = '0;
            for (int l = 0; l < LANES; l++) begin
                if (lane_wen[l] && lane_rd[l] == raddr[p]) begin
                    hit[p]      = 1'b1;
                    hit_lane[p] = lane_idx_t'(l);
                end
            end
            if (raddr[p] == '0) begin
                rdata[p] = '0;
            end else if (hit[p]) begin
                rdata[p] = lane_data[hit_lane[p]];  // Write-through
            end else begin
                rdata[p] = mem[raddr[p]];
            end
        end
    end

endmodule

`default_nettype wire

//--- stage_if.sv
`timescale 1ns/1ns
`default_nettype none

// One stage register of one lane, seen by forwarding and by writeback
interface stage_if import exe_cfg_pkg::*; ();
    logic     wen;     // Valid, writes rd, and rd is not r0
    reg_idx_t rd;
    data_t    result;
    logic     valid;

    modport src (output wen, rd, result, valid);
    modport fwd (input wen, rd, result);
    modport wb  (input wen, rd, result, valid);
endinterface

// Instruction in exe0 with its forwarded operands
interface exe0_if import exe_cfg_pkg::*, alu_op_pkg::*; ();
    logic     valid;
    alu_op_e  op;
    reg_idx_t rd;
    data_t    opj;
    data_t    opk;
    data_t    opd;

    modport drv  (output valid, op, rd, opj, opk, opd);
    modport lane (input valid, op, rd, opj, opk, opd);
endinterface

`default_nettype wire

//--- tb_exe_tests.svh
// Reset is held for three rising edges, writeback stays quiet throughout
task automatic reset_quiet();
    for (int i = 0; i < 3; i++) begin
        @(posedge clk);
        if (i == 2) begin
            rst_n <= 1'b1;
        end
        @(negedge clk);
        check(wb_valid, 2'b00, "wb_valid during reset");
    end
    repeat (5) begin
        @(negedge clk);
        check(wb_valid, 2'b00, "wb_valid after reset");
    end
endtask

task automatic every_opcode();
    alu_op_e op;
    for (int r = 1; r < REG_COUNT; r++) begin
        load_reg(reg_idx_t'(r), data_t'($urandom()));
    end
    // Signed compare goes both ways and one shift amount is the maximum
    load_reg(5'd1, 32'h7f0f_1234);
    load_reg(5'd2, 32'h0000_0007);
    load_reg(5'd3, 32'h8000_0010);
    load_reg(5'd4, 32'h0f0f_00ff);
    for (int i = 0; i <= int'(ALU_MERGE); i++) begin
        op = alu_op_e'(i);
        stage_op(0, op, reg_idx_t'(5 + 2 * i), 5'd1, 5'd2);
        stage_op(1, op, reg_idx_t'(6 + 2 * i), 5'd3, 5'd4);
        send_pair();
    end
    drain();
endtask

// Distance 1 to 3 hits s1 to s3, distance 4 the register file write-through
task automatic dependency_distances();
    for (int d = 1; d <= 4; d++) begin
        for (int l = 0; l < LANES; l++) begin
            for (int pos = 0; pos < 3; pos++) begin
                stage_op(l, ALU_ADD, 5'd24, 5'd24, 5'd2);  // New value every round
                send_pair();
                bubbles(d - 1);
                case (pos)
                    0:       stage_op(l, ALU_SUB, 5'd25, 5'd24, 5'd3);
                    1:       stage_op(l, ALU_XOR, 5'd25, 5'd4, 5'd24);
                    default: stage_op(l, ALU_MERGE, 5'd24, 5'd1, 5'd4);
                endcase
                send_pair();
            end
        end
    end
    drain();
endtask

task automatic cross_lane_and_same_rd();
    // Lane 0 picks up a result of lane 1 from an earlier pair
    for (int d = 1; d <= 4; d++) begin
        stage_op(0, ALU_AND, 5'd27, 5'd1, 5'd4);
        stage_op(1, ALU_ADD, 5'd26, 5'd26, 5'd3);
        send_pair();
        bubbles(d - 1);
        stage_op(0, ALU_SUB, 5'd27, 5'd26, 5'd2);
        send_pair();
    end
    // Both lanes write r28 and the reader must get lane 1's value
    for (int d = 1; d <= 5; d++) begin
        stage_op(0, ALU_ADD, 5'd28, 5'd1, 5'd2);
        stage_op(1, ALU_XOR, 5'd28, 5'd3, 5'd29);
        send_pair();
        bubbles(d - 1);
        stage_op(d % 2, ALU_OR, 5'd29, 5'd28, 5'd4);
        send_pair();
    end
    drain();
endtask

task automatic r0_rules();
    stage_op(0, ALU_ADD, 5'd0, 5'd1, 5'd2);
    stage_op(1, ALU_SUB, 5'd0, 5'd3, 5'd4);
    send_pair();
    stage_op(0, ALU_OR, 5'd30, 5'd0, 5'd0);  // Must not see the dropped r0 results
    stage_op(1, ALU_ADD, 5'd31, 5'd0, 5'd1);
    send_pair();
    stage_op(0, ALU_MERGE, 5'd30, 5'd1, 5'd0);
    send_pair();
    bubbles(4);
    stage_op(1, ALU_XOR, 5'd0, 5'd30, 5'd31);
    send_pair();
    drain();
endtask

function automatic logic lane1_depends();
    logic hit;
    hit = 1'b0;
    if (pend_valid == 2'b11 && pend_rd[0] != '0) begin
        hit = pend_rj[1] == pend_rd[0] || pend_rk[1] == pend_rd[0]
              || (pend_op[1] == ALU_MERGE && pend_rd[1] == pend_rd[0]);
    end
    return hit;
endfunction

task automatic random_stream();
    for (int n = 0; n < 200; n++) begin
        for (int l = 0; l < LANES; l++) begin
            if ($urandom_range(3) != 0) begin
                stage_op(l, alu_op_e'($urandom_range(8)), reg_idx_t'($urandom_range(31)),
                         reg_idx_t'($urandom_range(31)), reg_idx_t'($urandom_range(31)));
            end
        end
        while (lane1_depends()) begin
            pend_rj[1] = reg_idx_t'($urandom_range(31));
            pend_rk[1] = reg_idx_t'($urandom_range(31));
            pend_rd[1] = reg_idx_t'($urandom_range(31));
        end
        send_pair();
    end
    drain();
endtask

//--- tb_exe_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_exe_top import exe_cfg_pkg::*, alu_op_pkg::*; ();

    localparam int LANES       = 2;
    localparam int WB_DELAY    = 5;  // Falling edges from driving an issue to its writeback
    localparam int DRAIN_LIMIT = 20;

    typedef struct packed {
        logic [31:0] due;
        reg_idx_t    rd;
        data_t       data;
    } wb_exp_t;

    logic             clk;
    logic             rst_n;
    logic [LANES-1:0] issue_valid;
    alu_op_e  [LANES-1:0] issue_op;
    reg_idx_t [LANES-1:0] issue_rj;
    reg_idx_t [LANES-1:0] issue_rk;
    reg_idx_t [LANES-1:0] issue_rd;
    logic     [LANES-1:0] wb_valid;
    reg_idx_t [LANES-1:0] wb_rd;
    data_t    [LANES-1:0] wb_data;

    data_t    model [REG_COUNT];  // Architectural state in program order
    wb_exp_t  exp_q [LANES][$];
    int       cyc = 0;

    // The next pair to issue
    logic [LANES-1:0] pend_valid;
    alu_op_e  pend_op [LANES];
    reg_idx_t pend_rj [LANES];
    reg_idx_t pend_rk [LANES];
    reg_idx_t pend_rd [LANES];

    exe_top #(
        .LANES (LANES)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rj    (issue_rj),
        .issue_rk    (issue_rk),
        .issue_rd    (issue_rd),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAIL at %0t ns: %s, got %0h, expected %0h",
                                    $time, what, actual, expected));
        end
    endtask

    function automatic data_t alu_model(input alu_op_e op, input data_t j, input data_t k,
                                        input data_t d);
        data_t r;
        r = '0;
        case (op)
            ALU_ADD: r = j + k;
            ALU_SUB: r = j - k;
            ALU_AND: r = j & k;
            ALU_OR:  r = j | k;
            ALU_XOR: r = j ^ k;
            ALU_SLL: r = j << k[4:0];
            ALU_SRL: r = j >> k[4:0];
            ALU_SLT: r = (int'(j) < int'(k)) ? 32'd1 : 32'd0;
            ALU_MERGE: begin
                for (int b = 0; b < DATA_W; b++) begin
                    r[b] = k[b] ? j[b] : d[b];  // Bitwise select of rj or the old rd
                end
            end
            default: r = 'x;
        endcase
        return r;
    endfunction

    task automatic expect_wb(input int lane, input reg_idx_t rd, input data_t data);
        wb_exp_t e;
        e.due  = cyc + WB_DELAY;
        e.rd   = rd;
        e.data = data;
        exp_q[lane].push_back(e);
    endtask

    task automatic stage_op(input int lane, input alu_op_e op, input reg_idx_t rd,
                            input reg_idx_t rj, input reg_idx_t rk);
        pend_valid[lane] = 1'b1;
        pend_op[lane]    = op;
        pend_rd[lane]    = rd;
        pend_rj[lane]    = rj;
        pend_rk[lane]    = rk;
    endtask

    // Drives the staged pair, or a bubble, and runs it through the model
    task automatic send_pair();
        data_t res;
        @(posedge clk);
        issue_valid <= pend_valid;
        for (int l = 0; l < LANES; l++) begin
            issue_op[l] <= pend_op[l];
            issue_rj[l] <= pend_rj[l];
            issue_rk[l] <= pend_rk[l];
            issue_rd[l] <= pend_rd[l];
        end
        for (int l = 0; l < LANES; l++) begin
            if (pend_valid[l]) begin
                res = alu_model(pend_op[l], model[pend_rj[l]], model[pend_rk[l]],
                                model[pend_rd[l]]);
                if (pend_rd[l] != '0) begin
                    model[pend_rd[l]] = res;
                    expect_wb(l, pend_rd[l], res);
                end
            end
        end
        pend_valid = '0;
    endtask

    task automatic bubbles(input int n);
        repeat (n) send_pair();
    endtask

    // No immediates exist, so a load is an OR of r0 with the read data held at a value
    task automatic load_reg(input reg_idx_t r, input data_t v);
        @(posedge clk);
        issue_valid <= 2'b01;
        issue_op[0] <= ALU_OR;
        issue_rj[0] <= 5'd0;
        issue_rk[0] <= 5'd0;
        issue_rd[0] <= r;
        model[r] = v;
        expect_wb(0, r, v);
        #1 force i_dut.rf_rdata = {SRC_PER_LANE*LANES{v}};
        @(posedge clk);
        issue_valid <= '0;
        #1 release i_dut.rf_rdata;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            if (waited >= DRAIN_LIMIT) begin
                stop_on_error("Timeout: expected writebacks did not arrive");
            end else begin
                send_pair();
                waited++;
            end
        end
    endtask

    always @(negedge clk) begin : wb_monitor
        wb_exp_t e;
        cyc = cyc + 1;
        if (rst_n === 1'b1) begin
            for (int l = 0; l < LANES; l++) begin
                if (wb_valid[l] !== 1'b1) begin
                    check(wb_valid[l], 1'b0, $sformatf("wb_valid of lane %0d", l));
                end else if (exp_q[l].size() == 0) begin
                    stop_on_error($sformatf("Lane %0d wrote back r%0d but nothing was expected",
                                            l, wb_rd[l]));
                end else begin
                    e = exp_q[l].pop_front();
                    check(wb_rd[l], e.rd, $sformatf("wb_rd of lane %0d", l));
                    check(wb_data[l], e.data, $sformatf("wb_data of lane %0d, r%0d", l, e.rd));
                    check(cyc, e.due, $sformatf("writeback cycle of lane %0d", l));
                end
                if (exp_q[l].size() != 0 && exp_q[l][0].due <= cyc) begin
                    stop_on_error($sformatf("Writeback of r%0d on lane %0d never appeared",
                                            exp_q[l][0].rd, l));
                end
            end
        end
    end

    `include "tb_exe_tests.svh"

    initial begin
        void'($urandom(32'h2e5d));
        rst_n       = 1'b0;
        issue_valid = '0;
        issue_rj    = '0;
        issue_rk    = '0;
        issue_rd    = '0;
        pend_valid  = '0;
        for (int l = 0; l < LANES; l++) begin
            issue_op[l] = ALU_ADD;
            pend_op[l]  = ALU_ADD;
            pend_rj[l]  = '0;
            pend_rk[l]  = '0;
            pend_rd[l]  = '0;
        end
        for (int r = 0; r < REG_COUNT; r++) begin
            model[r] = '0;
        end

        reset_quiet();
        every_opcode();
        dependency_distances();
        cross_lane_and_same_rd();
        r0_rules();
        random_stream();

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
